// File: logic/rv32_macros.svh
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

// Width of a machine word and of every register
`define RV32_XLEN 32

// Width of the internal address path
// Bus addresses are padded with zeros above this width
`define RV32_ADDR_WIDTH 24

// First fetch address after reset
`define RV32_RESET_ADDR 0

// Size of the integer register file, x0 included
`define RV32_REG_COUNT 32

`endif

// File: logic/rv32IsaPkg.sv
`include "rv32_macros.svh"

package rv32IsaPkg;

   // Data word and internal address
   typedef logic [`RV32_XLEN-1:0] word_t;
   typedef logic [`RV32_ADDR_WIDTH-1:0] addr_t;
   typedef logic [4:0] regIndex_t;

   // Latched instruction, the two low bits are always 11 in RV32I
   typedef logic [31:2] instrWord_t;

   // Opcode field bits [6:2] of the ten base classes
   typedef enum logic [4:0] {
      OpLoad   = 5'b00000,
      OpAluImm = 5'b00100,
      OpAuipc  = 5'b00101,
      OpStore  = 5'b01000,
      OpAluReg = 5'b01100,
      OpLui    = 5'b01101,
      OpBranch = 5'b11000,
      OpJalr   = 5'b11001,
      OpJal    = 5'b11011,
      OpSystem = 5'b11100
   } opcode_t;

   typedef logic [2:0] funct3_t;

   // Funct3 values, used as bit positions in the one-hot funct3 vector
   // ALU operations
   localparam funct3_t F3AddSub = 3'd0;
   localparam funct3_t F3Sll    = 3'd1;
   localparam funct3_t F3Slt    = 3'd2;
   localparam funct3_t F3Sltu   = 3'd3;
   localparam funct3_t F3Xor    = 3'd4;
   localparam funct3_t F3SrlSra = 3'd5;
   localparam funct3_t F3Or     = 3'd6;
   localparam funct3_t F3And    = 3'd7;
   // Branch conditions
   localparam funct3_t F3Beq  = 3'd0;
   localparam funct3_t F3Bne  = 3'd1;
   localparam funct3_t F3Blt  = 3'd4;
   localparam funct3_t F3Bge  = 3'd5;
   localparam funct3_t F3Bltu = 3'd6;
   localparam funct3_t F3Bgeu = 3'd7;
   // Load and store sizes, U forms zero-extend
   localparam funct3_t F3Byte  = 3'd0;
   localparam funct3_t F3Half  = 3'd1;
   localparam funct3_t F3ByteU = 3'd4;
   localparam funct3_t F3HalfU = 3'd5;

   // Everything the datapath needs to know about the current instruction
   typedef struct packed {
      logic isLoad;
      logic isAluImm;
      logic isAuipc;
      logic isStore;
      logic isAluReg;
      logic isLui;
      logic isBranch;
      logic isJalr;
      logic isJal;
      logic isSystem;
      logic isAlu;
      logic [7:0] funct3Is;
      regIndex_t rd;
      regIndex_t rs1;
      regIndex_t rs2;
      word_t uImm;
      word_t iImm;
      word_t sImm;
      word_t bImm;
      word_t jImm;
      logic isSub;
      logic isArithShift;
      logic isShift;
   } decodedInstr_t;

endpackage

// File: logic/rv32BusPkg.sv
package rv32BusPkg;

   import rv32IsaPkg::*;

   // One enable bit per byte lane
   typedef logic [3:0] wmask_t;

   // Core to memory
   // A read is one cycle of rstrb, a write is one cycle of nonzero wmask
   typedef struct packed {
      logic [31:0] addr;
      word_t wdata;
      wmask_t wmask;
      logic rstrb;
   } memReq_t;

   // Memory to core
   // rdata is valid in the first cycle after the strobe with rbusy low
   typedef struct packed {
      word_t rdata;
      logic rbusy;
      logic wbusy;
   } memRsp_t;

endpackage

// File: logic/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder import rv32IsaPkg::*; (
   input  instrWord_t    instrWord,
   output decodedInstr_t decoded
);

   opcode_t opcode;

   // Opcode field only, bits 1:0 are not kept
   assign opcode = opcode_t'(instrWord[6:2]);

   always_comb begin
      // Class flags, exactly one is set for a legal opcode
      decoded.isLoad   = (opcode == OpLoad);
      decoded.isAluImm = (opcode == OpAluImm);
      decoded.isAuipc  = (opcode == OpAuipc);
      decoded.isStore  = (opcode == OpStore);
      decoded.isAluReg = (opcode == OpAluReg);
      decoded.isLui    = (opcode == OpLui);
      decoded.isBranch = (opcode == OpBranch);
      decoded.isJalr   = (opcode == OpJalr);
      decoded.isJal    = (opcode == OpJal);
      decoded.isSystem = (opcode == OpSystem);
      decoded.isAlu    = decoded.isAluImm | decoded.isAluReg;

      // Funct3 expanded to one-hot
      decoded.funct3Is = 8'b0000_0001 << instrWord[14:12];

      // Register indices
      decoded.rd  = instrWord[11:7];
      decoded.rs1 = instrWord[19:15];
      decoded.rs2 = instrWord[24:20];

      // U type, upper 20 bits
      decoded.uImm = {instrWord[31:12], 12'b0};
      // I type, loads, JALR and ALU immediates
      decoded.iImm = {{21{instrWord[31]}}, instrWord[30:20]};
      // S type, offset split around rd field
      decoded.sImm = {{21{instrWord[31]}}, instrWord[30:25], instrWord[11:7]};
      // B type, always even
      decoded.bImm = {{20{instrWord[31]}}, instrWord[7], instrWord[30:25],
                      instrWord[11:8], 1'b0};
      // J type, always even
      decoded.jImm = {{12{instrWord[31]}}, instrWord[19:12], instrWord[20],
                      instrWord[30:21], 1'b0};

      // Bit 30 selects SUB only in register form
      // ADDI reuses that bit as immediate
      decoded.isSub = instrWord[30] & decoded.isAluReg;

      // Bit 30 also picks SRA over SRL
      decoded.isArithShift = instrWord[30];

      // Shifts need the multicycle path
      decoded.isShift = decoded.isAlu &
                        (decoded.funct3Is[F3Sll] | decoded.funct3Is[F3SrlSra]);
   end

endmodule

// File: logic/registerFile.sv
`timescale 1ns/10ps
`include "rv32_macros.svh"

module registerFile import rv32IsaPkg::*; (
   input  logic      clk,
   input  logic      readAccept,
   input  regIndex_t rs1Index,
   input  regIndex_t rs2Index,
   output word_t     rs1Data,
   output word_t     rs2Data,
   input  logic      writeEnable,
   input  regIndex_t rd,
   input  word_t     writeData
);

   word_t regs [`RV32_REG_COUNT];

   always_ff @(posedge clk) begin
      // x0 is never written
      if (writeEnable && rd != '0) begin
         regs[rd] <= writeData;
      end
      // Both operands captured as the instruction word arrives
      // Index zero always reads as zero
      if (readAccept) begin
         rs1Data <= (rs1Index == '0) ? '0 : regs[rs1Index];
         rs2Data <= (rs2Index == '0) ? '0 : regs[rs2Index];
      end
   end

endmodule

// File: logic/aluShifter.sv
`timescale 1ns/10ps
`include "rv32_macros.svh"

module aluShifter import rv32IsaPkg::*; (
   input  logic          clk,
   input  decodedInstr_t decoded,
   input  word_t         rs1Data,
   input  word_t         rs2Data,
   input  logic          start,
   output word_t         aluResult,
   output word_t         aluSum,
   output logic          branchTaken,
   output logic          busy
);

   word_t aluIn2;
   word_t addSub;
   logic [`RV32_XLEN:0] aluMinus;
   logic lessThan;
   logic lessThanU;
   logic equal;
   logic shiftFunct;
   word_t shiftReg;
   logic [4:0] shiftAmount;

   // Register operand for reg-reg ALU and branches, I-immediate otherwise
   assign aluIn2 = (decoded.isAluReg | decoded.isBranch) ? rs2Data : decoded.iImm;

   // Shared adder, also the JALR target
   assign aluSum = rs1Data + aluIn2;

   // One 33 bit subtract gives SUB and every comparison
   // Top bit is the borrow out
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1Data} + 1'b1;
   assign lessThanU = aluMinus[`RV32_XLEN];
   // Signs differ -> rs1 is less when it is the negative one
   assign lessThan = (rs1Data[`RV32_XLEN-1] ^ aluIn2[`RV32_XLEN-1]) ?
                     rs1Data[`RV32_XLEN-1] : aluMinus[`RV32_XLEN];
   assign equal = (aluMinus[`RV32_XLEN-1:0] == '0);

   assign addSub = decoded.isSub ? aluMinus[`RV32_XLEN-1:0] : aluSum;
   assign shiftFunct = decoded.funct3Is[F3Sll] | decoded.funct3Is[F3SrlSra];

   // One-hot funct3, so the terms can simply be OR-ed
   assign aluResult = (decoded.funct3Is[F3AddSub] ? addSub : '0)
                    | (decoded.funct3Is[F3Slt] ? word_t'(lessThan) : '0)
                    | (decoded.funct3Is[F3Sltu] ? word_t'(lessThanU) : '0)
                    | (decoded.funct3Is[F3Xor] ? (rs1Data ^ aluIn2) : '0)
                    | (decoded.funct3Is[F3Or] ? (rs1Data | aluIn2) : '0)
                    | (decoded.funct3Is[F3And] ? (rs1Data & aluIn2) : '0)
                    | (shiftFunct ? shiftReg : '0);

   // Branch predicate, funct3 picks the condition
   assign branchTaken = (decoded.funct3Is[F3Beq] & equal)
                      | (decoded.funct3Is[F3Bne] & ~equal)
                      | (decoded.funct3Is[F3Blt] & lessThan)
                      | (decoded.funct3Is[F3Bge] & ~lessThan)
                      | (decoded.funct3Is[F3Bltu] & lessThanU)
                      | (decoded.funct3Is[F3Bgeu] & ~lessThanU);

   // Bit-serial shifter, one position per clock
   always_ff @(posedge clk) begin
      if (start && decoded.isShift) begin
         // Shamt comes from rs2 or the immediate low bits
         shiftReg <= rs1Data;
         shiftAmount <= aluIn2[4:0];
      end else if (|shiftAmount) begin
         shiftAmount <= shiftAmount - 5'd1;
         if (decoded.funct3Is[F3Sll]) begin
            shiftReg <= shiftReg << 1;
         end else begin
            // SRA feeds the sign back in, SRL feeds zero
            shiftReg <= {decoded.isArithShift & shiftReg[`RV32_XLEN-1],
                         shiftReg[`RV32_XLEN-1:1]};
         end
      end
   end

   // Busy until the remaining amount reaches zero
   assign busy = decoded.isShift & (|shiftAmount);

endmodule

// File: logic/loadStoreUnit.sv
`timescale 1ns/10ps
`include "rv32_macros.svh"

module loadStoreUnit import rv32IsaPkg::*; import rv32BusPkg::*; (
   input  decodedInstr_t decoded,
   input  word_t         rs1Data,
   input  word_t         rs2Data,
   input  word_t         rdata,
   output addr_t         accessAddr,
   output word_t         wdata,
   output wmask_t        storeMask,
   output word_t         loadData
);

   logic byteAccess;
   logic halfAccess;
   logic loadUnsigned;
   logic loadSign;
   logic [15:0] loadHalf;
   logic [7:0] loadByte;

   // Size from funct3, the U forms share the same low bits
   assign byteAccess = decoded.funct3Is[F3Byte] | decoded.funct3Is[F3ByteU];
   assign halfAccess = decoded.funct3Is[F3Half] | decoded.funct3Is[F3HalfU];
   assign loadUnsigned = decoded.funct3Is[F3ByteU] | decoded.funct3Is[F3HalfU];

   // Dedicated address adder, S offset for stores and I offset for loads
   assign accessAddr = rs1Data[`RV32_ADDR_WIDTH-1:0] +
                       (decoded.isStore ? decoded.sImm[`RV32_ADDR_WIDTH-1:0] :
                                          decoded.iImm[`RV32_ADDR_WIDTH-1:0]);

   // Store data copied onto every lane it may land in
   assign wdata[7:0]   = rs2Data[7:0];
   assign wdata[15:8]  = accessAddr[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign wdata[23:16] = accessAddr[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign wdata[31:24] = accessAddr[0] ? rs2Data[7:0] :
                         accessAddr[1] ? rs2Data[15:8] : rs2Data[31:24];

   // Byte -> one lane, halfword -> lane pair, word -> all four
   always_comb begin
      if (byteAccess) begin
         storeMask = wmask_t'(4'b0001 << accessAddr[1:0]);
      end else if (halfAccess) begin
         storeMask = accessAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

   // Pick the addressed halfword, then the byte inside it
   assign loadHalf = accessAddr[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = accessAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   assign loadSign = ~loadUnsigned & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  rdata;

endmodule

// File: logic/rv32Core.sv
`timescale 1ns/10ps
`include "rv32_macros.svh"

module rv32Core import rv32IsaPkg::*; import rv32BusPkg::*; (
   input  logic    clk,
   input  logic    reset,
   output memReq_t memReq,
   input  memRsp_t memRsp
);

   // One-hot sequencer, bit positions
   localparam int FetchInstrBit = 0;
   localparam int WaitInstrBit = 1;
   localparam int ExecuteBit = 2;
   localparam int WaitAluOrMemBit = 3;

   // ADDI x0, x0, 0 without the two low bits
   localparam instrWord_t NopInstr = 30'h0000_0004;

   logic [3:0] state;
   addr_t pc;
   instrWord_t instr;
   decodedInstr_t decoded;
   word_t rs1Data;
   word_t rs2Data;
   word_t aluResult;
   word_t aluSum;
   logic branchTaken;
   logic aluBusy;
   addr_t accessAddr;
   word_t storeData;
   wmask_t storeMask;
   word_t loadData;
   addr_t pcPlus4;
   addr_t pcPlusImm;
   logic needToWait;
   logic waitDone;
   logic writeEnable;
   word_t writeBackData;

   instrDecoder decoder (.instrWord(instr), .decoded(decoded));

   // Operand indices straight from the word coming off the bus
   registerFile regFile (
      .clk        (clk),
      .readAccept (state[WaitInstrBit] & ~memRsp.rbusy),
      .rs1Index   (memRsp.rdata[19:15]),
      .rs2Index   (memRsp.rdata[24:20]),
      .rs1Data    (rs1Data),
      .rs2Data    (rs2Data),
      .writeEnable(writeEnable),
      .rd         (decoded.rd),
      .writeData  (writeBackData)
   );

   aluShifter alu (
      .clk        (clk),
      .decoded    (decoded),
      .rs1Data    (rs1Data),
      .rs2Data    (rs2Data),
      .start      (state[ExecuteBit] & decoded.isAlu),
      .aluResult  (aluResult),
      .aluSum     (aluSum),
      .branchTaken(branchTaken),
      .busy       (aluBusy)
   );

   loadStoreUnit lsu (
      .decoded   (decoded),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .rdata     (memRsp.rdata),
      .accessAddr(accessAddr),
      .wdata     (storeData),
      .storeMask (storeMask),
      .loadData  (loadData)
   );

   assign pcPlus4 = pc + addr_t'(4);
   // Single adder for JAL, AUIPC and branch targets
   assign pcPlusImm = pc + (decoded.isJal   ? decoded.jImm[`RV32_ADDR_WIDTH-1:0] :
                            decoded.isAuipc ? decoded.uImm[`RV32_ADDR_WIDTH-1:0] :
                                              decoded.bImm[`RV32_ADDR_WIDTH-1:0]);

   // Memory access or shift in progress after Execute
   assign needToWait = decoded.isLoad | decoded.isStore | decoded.isShift;
   assign waitDone = ~aluBusy & ~memRsp.rbusy & ~memRsp.wbusy;

   // Execute writes single-cycle results, the wait state finishes loads and shifts
   assign writeEnable =
      (state[ExecuteBit] & ~(decoded.isBranch | decoded.isStore |
                             decoded.isSystem | needToWait)) |
      (state[WaitAluOrMemBit] & waitDone & (decoded.isLoad | decoded.isShift));

   // Write-back selection, at most one source is active
   assign writeBackData = (decoded.isLui ? decoded.uImm : '0)
                        | (decoded.isAlu ? aluResult : '0)
                        | (decoded.isAuipc ? word_t'(pcPlusImm) : '0)
                        | ((decoded.isJal | decoded.isJalr) ? word_t'(pcPlus4) : '0)
                        | (decoded.isLoad ? loadData : '0);

   // Bus drive
   // Fetch phases put the PC out, the rest the data address
   assign memReq.addr = 32'((state[FetchInstrBit] | state[WaitInstrBit]) ? pc : accessAddr);
   assign memReq.wdata = storeData;
   assign memReq.wmask = {4{state[ExecuteBit] & decoded.isStore}} & storeMask;
   assign memReq.rstrb = state[FetchInstrBit] | (state[ExecuteBit] & decoded.isLoad);

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by draining any write still pending in memory
         state <= 4'(1 << WaitAluOrMemBit);
         pc <= addr_t'(`RV32_RESET_ADDR);
         instr <= NopInstr;
      end else begin
         case (1'b1)
            state[WaitInstrBit]: begin
               // Hold until the fetched word is there
               if (!memRsp.rbusy) begin
                  instr <= memRsp.rdata[31:2];
                  state <= 4'(1 << ExecuteBit);
               end
            end
            state[ExecuteBit]: begin
               if (decoded.isJalr) begin
                  pc <= aluSum[`RV32_ADDR_WIDTH-1:0];
               end else if (decoded.isJal | (decoded.isBranch & branchTaken)) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               state <= needToWait ? 4'(1 << WaitAluOrMemBit) : 4'(1 << FetchInstrBit);
            end
            state[WaitAluOrMemBit]: begin
               if (waitDone) begin
                  state <= 4'(1 << FetchInstrBit);
               end
            end
            default: begin
               // FetchInstr, strobe is out this cycle
               state <= 4'(1 << WaitInstrBit);
            end
         endcase
      end
   end

endmodule

// File: tb/rv32Core_properties.sv
`timescale 1ns/10ps

module rv32CoreProperties import rv32BusPkg::*; (
   input logic       clk,
   input logic       reset,
   input logic [3:0] state,
   input memReq_t    memReq,
   input memRsp_t    memRsp
);

   logic stalled;
   // Number of assertion failures so far
   int failCount = 0;

   // WaitInstr stalls on rbusy and WaitAluOrMem on either busy
   assign stalled = (state[1] & memRsp.rbusy) |
                    (state[3] & (memRsp.rbusy | memRsp.wbusy));

   // No write during reset once the state is known
   resetQuiet: assert property (@(posedge clk)
      (!reset && !$isunknown(state)) |-> (memReq.wmask == '0))
      else begin
         failCount++;
         $error("write mask nonzero during reset");
      end

   // Request frozen during a stall
   holdWhileStalled: assert property (@(posedge clk) disable iff (!reset)
      stalled |=> $stable(memReq))
      else begin
         failCount++;
         $error("bus request changed while stalled");
      end

   // Byte lanes, lane pairs or the full word
   legalMask: assert property (@(posedge clk) disable iff (!reset)
      (|memReq.wmask) |->
         (memReq.wmask inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                               4'b0011, 4'b1100, 4'b1111}))
      else begin
         failCount++;
         $error("illegal write mask %b", memReq.wmask);
      end

   // Read and write never share a cycle
   noReadWrite: assert property (@(posedge clk) disable iff (!reset)
      !(memReq.rstrb && (|memReq.wmask)))
      else begin
         failCount++;
         $error("read strobe and write mask in the same cycle");
      end

endmodule

// File: tb/rv32CoreTb.sv
`timescale 1ns/10ps
`include "rv32_macros.svh"

module rv32CoreTb import rv32IsaPkg::*; import rv32BusPkg::*; ;

   // One expected bus write
   // Only lanes enabled in the mask are compared
   typedef struct packed {
      logic [31:0] addr;
      wmask_t mask;
      word_t data;
   } expWrite_t;

   logic clk = 1'b0;
   logic reset;
   memReq_t memReq;
   memRsp_t memRsp;
   word_t rdata;
   logic rbusy;
   logic wbusy;
   logic busyOn;
   logic firstFetch;
   logic timedOut;
   logic [31:0] readAddr;
   word_t mem [4096];
   word_t image [4096];
   word_t prog [$];
   expWrite_t expected [$];
   expWrite_t pending [$];
   int slot;
   int errorCount;
   int checkCount;

   always #2 clk = ~clk;

   assign rdata = mem[readAddr[13:2]];
   assign memRsp = {rdata, rbusy, wbusy};

   rv32Core DUT (.clk(clk), .reset(reset), .memReq(memReq), .memRsp(memRsp));

   bind rv32Core rv32CoreProperties props (
      .clk(clk), .reset(reset), .state(state), .memReq(memReq), .memRsp(memRsp));

   // Instruction encoders in the standard RV32I field layout
   function automatic word_t encR(logic [6:0] f7, regIndex_t rs2, regIndex_t rs1,
                                  funct3_t f3, regIndex_t rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic word_t encI(logic [11:0] imm, regIndex_t rs1, funct3_t f3,
                                  regIndex_t rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t encS(logic [11:0] imm, regIndex_t rs2, regIndex_t rs1,
                                  funct3_t f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic word_t encB(logic [12:0] imm, regIndex_t rs2, regIndex_t rs1,
                                  funct3_t f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic word_t encU(logic [19:0] imm, regIndex_t rd, logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic word_t encJ(logic [20:0] imm, regIndex_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // Expected ALU result for each funct3
   function automatic word_t aluRef(funct3_t f3, logic alt, word_t a, word_t b);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return word_t'($signed(a) < $signed(b));
         3'd3: return word_t'(a < b);
         3'd4: return a ^ b;
         3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchRef(funct3_t f3, word_t a, word_t b);
      case (f3)
         3'd0: return a == b;
         3'd1: return a != b;
         3'd4: return $signed(a) < $signed(b);
         3'd5: return $signed(a) >= $signed(b);
         3'd6: return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic word_t loadRef(funct3_t f3, word_t w, int k);
      logic [7:0] b8;
      logic [15:0] b16;
      b8 = w[8*k +: 8];
      b16 = w[8*k +: 16];
      if (!f3[0]) begin
         return f3[2] ? {24'b0, b8} : {{24{b8[7]}}, b8};
      end
      return f3[2] ? {16'b0, b16} : {{16{b16[15]}}, b16};
   endfunction

   function automatic word_t laneBits(wmask_t m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   function automatic void emit(word_t w);
      prog.push_back(w);
   endfunction

   // SW into the next result slot at 0x2000 (x5)
   function automatic void storeResult(regIndex_t rs, word_t value, logic keep);
      emit(encS(12'(slot * 4), rs, 5'd5, 3'd2));
      if (keep) begin
         expected.push_back('{32'h2000 + slot * 4, 4'hF, value});
      end
      slot++;
   endfunction

   task automatic buildProgram();
      word_t a;
      word_t b;
      logic [11:0] imm;
      logic [19:0] upper;
      funct3_t f3;
      logic alt;
      int base;
      regIndex_t pairA [3];
      regIndex_t pairB [3];
      for (int i = 0; i < 4096; i++) begin
         image[i] = {16'(i) ^ 16'hA5A5, 16'(i)};
      end
      // Data area at 0x1000 holds two random operands and a fixed lane pattern
      image[1024] = $urandom;
      image[1025] = $urandom;
      image[1026] = 32'h7F80FF01;
      a = image[1024];
      b = image[1025];
      slot = 0;
      emit(encU(20'h2, 5'd5, 7'b0110111));
      emit(encU(20'h1, 5'd6, 7'b0110111));
      emit(encI(12'd0, 5'd6, 3'd2, 5'd1, 7'b0000011));
      emit(encI(12'd4, 5'd6, 3'd2, 5'd2, 7'b0000011));
      // Register-register forms with SUB and SRA last
      for (int k = 0; k < 10; k++) begin
         f3 = (k < 8) ? funct3_t'(k) : ((k == 8) ? 3'd0 : 3'd5);
         alt = (k >= 8);
         emit(encR(alt ? 7'b0100000 : 7'b0, 5'd2, 5'd1, f3, 5'd3));
         storeResult(5'd3, aluRef(f3, alt, a, b), 1'b1);
      end
      // Register-immediate without shifts
      for (int k = 0; k < 8; k++) begin
         if (k != 1 && k != 5) begin
            imm = 12'($urandom);
            emit(encI(imm, 5'd1, funct3_t'(k), 5'd3, 7'b0010011));
            storeResult(5'd3, aluRef(funct3_t'(k), 1'b0, a, {{20{imm[11]}}, imm}), 1'b1);
         end
      end
      // SLLI, SRLI and SRAI over every amount
      for (int sh = 0; sh < 32; sh++) begin
         for (int kind = 0; kind < 3; kind++) begin
            f3 = (kind == 0) ? 3'd1 : 3'd5;
            alt = (kind == 2);
            emit(encI({alt ? 7'b0100000 : 7'b0, 5'(sh)}, 5'd1, f3, 5'd3, 7'b0010011));
            storeResult(5'd3, aluRef(f3, alt, a, word_t'(sh)), 1'b1);
         end
      end
      // x0 stays zero
      emit(encI(12'h07B, 5'd0, 3'd0, 5'd0, 7'b0010011));
      storeResult(5'd0, '0, 1'b1);
      // LB, LH, LBU, LHU at every legal offset of the word at 0x1008
      for (int f = 0; f < 8; f++) begin
         if (f == 0 || f == 1 || f == 4 || f == 5) begin
            for (int k = 0; k < 4; k += (f % 2 == 1) ? 2 : 1) begin
               emit(encI(12'(8 + k), 5'd6, funct3_t'(f), 5'd3, 7'b0000011));
               storeResult(5'd3, loadRef(funct3_t'(f), image[1026], k), 1'b1);
            end
         end
      end
      // SB, SH and SW lanes and masks
      for (int k = 0; k < 4; k++) begin
         emit(encS(12'(16 + k), 5'd2, 5'd6, 3'd0));
         expected.push_back('{32'h1010 + k, wmask_t'(1 << k), word_t'(b[7:0]) << (8 * k)});
      end
      for (int k = 0; k < 4; k += 2) begin
         emit(encS(12'(20 + k), 5'd2, 5'd6, 3'd1));
         expected.push_back('{32'h1014 + k, wmask_t'(3 << k), word_t'(b[15:0]) << (8 * k)});
      end
      emit(encS(12'd24, 5'd2, 5'd6, 3'd2));
      expected.push_back('{32'h1018, 4'hF, b});
      // Each branch jumps over one store when taken
      pairA = '{5'd1, 5'd2, 5'd1};
      pairB = '{5'd2, 5'd1, 5'd1};
      for (int p = 0; p < 3; p++) begin
         for (int k = 0; k < 8; k++) begin
            if (k != 2 && k != 3) begin
               emit(encB(13'd8, pairB[p], pairA[p], funct3_t'(k)));
               storeResult(5'd2, b, !branchRef(funct3_t'(k), (pairA[p] == 1) ? a : b,
                                                (pairB[p] == 1) ? a : b));
            end
         end
      end
      // Countdown loop stores three values into one slot
      emit(encI(12'd3, 5'd0, 3'd0, 5'd8, 7'b0010011));
      emit(encI(12'hFFF, 5'd8, 3'd0, 5'd8, 7'b0010011));
      emit(encS(12'(slot * 4), 5'd8, 5'd5, 3'd2));
      emit(encB(13'h1FF8, 5'd0, 5'd8, 3'd1));
      for (int v = 2; v >= 0; v--) begin
         expected.push_back('{32'h2000 + slot * 4, 4'hF, word_t'(v)});
      end
      slot++;
      // JAL over one store
      base = prog.size() * 4;
      emit(encJ(21'd8, 5'd9));
      storeResult(5'd0, '0, 1'b0);
      storeResult(5'd9, word_t'(base + 4), 1'b1);
      // AUIPC gives its own PC and JALR lands two words past it
      base = prog.size() * 4;
      emit(encU(20'h0, 5'd10, 7'b0010111));
      storeResult(5'd10, word_t'(base), 1'b1);
      emit(encI(12'd16, 5'd10, 3'd0, 5'd11, 7'b1100111));
      storeResult(5'd0, '0, 1'b0);
      storeResult(5'd11, word_t'(base + 12), 1'b1);
      upper = 20'($urandom);
      emit(encU(upper, 5'd12, 7'b0110111));
      storeResult(5'd12, {upper, 12'b0}, 1'b1);
      // Park on a jump to itself
      emit(encJ(21'd0, 5'd0));
      foreach (prog[i]) begin
         image[i] = prog[i];
      end
   endtask

   task automatic checkWrite(logic [31:0] addr, wmask_t mask, word_t data);
      expWrite_t e;
      assert (pending.size() > 0) else begin
         errorCount++;
         $display("[ERROR] %0t write to %h after the last expected write", $time, addr);
      end
      if (pending.size() > 0) begin
         e = pending.pop_front();
         checkCount++;
         assert (addr == e.addr && mask == e.mask &&
                 (data & laneBits(mask)) == (e.data & laneBits(mask))) else begin
            errorCount++;
            $display("[ERROR] %0t write %h mask %b data %h, expected %h mask %b data %h",
                     $time, addr, mask, data, e.addr, e.mask, e.data);
         end
      end
   endtask

   // Memory model samples the request at the edge and drives busy 1 ns later
   always @(posedge clk) begin
      if (reset) begin
         if (memReq.rstrb && firstFetch) begin
            checkCount++;
            assert (memReq.addr == 32'(`RV32_RESET_ADDR)) else begin
               errorCount++;
               $display("[ERROR] %0t first fetch at %h", $time, memReq.addr);
            end
            firstFetch <= 1'b0;
         end
         if (memReq.rstrb) begin
            readAddr <= memReq.addr;
         end
         if (|memReq.wmask) begin
            checkWrite(memReq.addr, memReq.wmask, memReq.wdata);
            for (int k = 0; k < 4; k++) begin
               if (memReq.wmask[k]) begin
                  mem[memReq.addr[13:2]][8*k +: 8] <= memReq.wdata[8*k +: 8];
               end
            end
         end
      end
      #1;
      rbusy <= busyOn && ($urandom % 3 == 0);
      wbusy <= busyOn && ($urandom % 3 == 0);
   end

   task automatic reportTimeout(string what);
      $display("Timeout: %s did not happen in time", what);
      timedOut = 1'b1;
   endtask

   task automatic runProgram(logic withBusy);
      int cycles;
      // Program area is never stored to, so the parked core still fetches the same jump
      for (int i = 0; i < 4096; i++) begin
         mem[i] = image[i];
      end
      @(posedge clk);
      #1 reset = 1'b0;
      busyOn = withBusy;
      firstFetch = 1'b1;
      pending = expected;
      repeat (4) @(posedge clk);
      #1 reset = 1'b1;
      cycles = 0;
      while (firstFetch) begin
         @(posedge clk);
         cycles++;
         if (cycles > 50) begin
            reportTimeout("first instruction fetch");
            return;
         end
      end
      cycles = 0;
      while (pending.size() > 0) begin
         @(posedge clk);
         cycles++;
         if (cycles > 50000) begin
            reportTimeout("the last expected store");
            return;
         end
      end
   endtask

   initial begin
      void'($urandom(32'h1882));
      reset = 1'b0;
      busyOn = 1'b0;
      rbusy = 1'b0;
      wbusy = 1'b0;
      readAddr = '0;
      firstFetch = 1'b1;
      timedOut = 1'b0;
      errorCount = 0;
      checkCount = 0;
      buildProgram();
      // Same image twice with random back-pressure on the second pass
      runProgram(1'b0);
      if (!timedOut) begin
         runProgram(1'b1);
      end
      $display("Checks %0d, errors %0d, assertion failures %0d",
               checkCount, errorCount, DUT.props.failCount);
      if (errorCount == 0 && DUT.props.failCount == 0 && !timedOut) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: list.f
+incdir+logic
logic/rv32IsaPkg.sv
logic/rv32BusPkg.sv
logic/instrDecoder.sv
logic/registerFile.sv
logic/aluShifter.sv
logic/loadStoreUnit.sv
logic/rv32Core.sv
tb/rv32Core_properties.sv
tb/rv32CoreTb.sv

// File: Bender.yml
package:
  name: rv32_core

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv32IsaPkg.sv
      - logic/rv32BusPkg.sv
      - logic/instrDecoder.sv
      - logic/registerFile.sv
      - logic/aluShifter.sv
      - logic/loadStoreUnit.sv
      - logic/rv32Core.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/rv32Core_properties.sv
      - tb/rv32CoreTb.sv
